// ==== flist.f ====
+incdir+verification
hw/matcalc_pkg.sv
hw/uart_rx.sv
hw/num_parser.sv
hw/matrix_engine.sv
hw/matrix_printer.sv
hw/uart_tx.sv
hw/matcalc_top.sv
verification/tb_matcalc.sv

// ==== verification/tb_uart_util.svh ====
`ifndef TB_UART_UTIL_SVH
`define TB_UART_UTIL_SVH

// --------------------------------------------------
// Pseudo-random bits
// --------------------------------------------------
// Fibonacci LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_bit();
    logic fb;
    fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [15:0] random_value(input int bits);
    logic [15:0] v;
    int          i;
    v = '0;
    for (i = 0; i < bits; i++) v = {v[14:0], lfsr_bit()};  // One step per bit
    return v;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        error_count++;
    end
endtask

// --------------------------------------------------
// Serial line
// --------------------------------------------------
task automatic send_byte(input logic [7:0] b);
    int i;
    @(negedge clk);
    rx = 1'b0;  // Start bit
    repeat (BIT_CLKS) @(negedge clk);
    for (i = 0; i < 8; i++) begin
        rx = b[i];
        repeat (BIT_CLKS) @(negedge clk);
    end
    rx = 1'b1;
    repeat (BIT_CLKS) @(negedge clk);
endtask

task automatic send_string(input string s);
    int i;
    for (i = 0; i < s.len(); i++) send_byte(s[i]);
endtask

// Runs forever, decodes every frame on tx into rx_q
task automatic receive_frames();
    logic [7:0] c;
    int         i;
    forever begin
        @(negedge tx);
        repeat (BIT_CLKS / 2) @(negedge clk);  // Middle of start bit
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            c[i] = tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        if (tx) begin
            rx_q.push_back(c);
        end else begin
            $display("Stop bit on tx was low, character 0x%0h dropped", c);
            error_count++;
        end
    end
endtask

// Reply ends with a newline after "]" or "E"
task automatic collect_reply(output string reply, output bit ok);
    logic [7:0] c;
    logic [7:0] prev;
    bit         done;
    int         waited;
    reply = "";
    prev  = 8'h00;
    done  = 1'b0;
    ok    = 1'b1;
    while (!done && ok) begin
        waited = 0;
        while (rx_q.size() == 0 && waited < CHAR_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_q.size() == 0) begin
            $display("No reply character arrived on tx in time, reply so far \"%s\"", reply);
            error_count++;
            ok = 1'b0;
        end else begin
            c     = rx_q.pop_front();
            done  = c == "\n" && (prev == "]" || prev == "E");
            reply = $sformatf("%s%c", reply, c);
            prev  = c;
        end
    end
endtask

`endif

// ==== verification/tb_matcalc.sv ====
module tb_matcalc;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CLKS      = 8;
    localparam int DEPTH         = 4;
    localparam int CLK_PERIOD_NS = 4;
    localparam int CHAR_TIMEOUT  = 30 * 10 * BIT_CLKS;  // Cycles between reply characters
    // Watchdog bounds from numbers sent and characters received
    localparam int NUM_COUNT     = 84;
    localparam int SENT_MAX      = NUM_COUNT * 7;       // Five digits plus separators
    localparam int RECV_MAX      = 36 * 6 + 5 * 3 + 3 * 2;
    localparam int WATCHDOG_NS   = (SENT_MAX + RECV_MAX) * 10 * BIT_CLKS * CLK_PERIOD_NS * 2;

    logic        clk;
    logic        rst_n;
    logic        rx;
    logic        tx;
    logic [15:0] lfsr_state;
    logic [7:0]  rx_q [$];
    int          error_count = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    logic [15:0] a_model   [16];
    logic [15:0] b_model   [16];
    logic [15:0] res_model [16];

    `include "tb_uart_util.svh"

    matcalc_top #(.CLKS_PER_BIT(BIT_CLKS), .TX_DEPTH(DEPTH)) dut (
        .clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    initial receive_frames();

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic string format_result(input int rows, input int cols);
        string s;
        int    r;
        int    c;
        s = "[";
        for (r = 0; r < rows; r++) begin
            for (c = 0; c < cols; c++) begin
                s = $sformatf("%s%0d", s, res_model[r * cols + c]);
                if (c != cols - 1) s = $sformatf("%s ", s);
                else if (r != rows - 1) s = $sformatf("%s\n", s);
            end
        end
        return $sformatf("%s]\n", s);
    endfunction

    function automatic string sep_text(input int i);
        case (i % 4)
            0:       return ", ";
            1:       return "\n";
            2:       return ";";
            default: return " ";
        endcase
    endfunction

    task automatic build_add(input int m, input int n, input bit zeros,
                             output string cmd, output string expected);
        int i;
        cmd = $sformatf("%0d %0d %0d ", int'(matcalc_pkg::OP_ADD), m, n);
        for (i = 0; i < m * n; i++) begin
            a_model[i] = random_value(10) % 16'd1000;
            b_model[i] = random_value(10) % 16'd1000;
            if (zeros && i % 5 == 0) begin  // Diagonal of a 4x4
                a_model[i] = '0;
                b_model[i] = '0;
            end
            res_model[i] = a_model[i] + b_model[i];
        end
        for (i = 0; i < m * n; i++) cmd = $sformatf("%s%0d ", cmd, a_model[i]);
        for (i = 0; i < m * n; i++) cmd = $sformatf("%s%0d ", cmd, b_model[i]);
        expected = format_result(m, n);
    endtask

    task automatic build_scale(input int m, input int n, output string cmd,
                               output string expected);
        logic [31:0] prod;
        logic [15:0] k;
        int          i;
        cmd = $sformatf("%0d %0d %0d ", int'(matcalc_pkg::OP_SCALE), m, n);
        k   = random_value(16);
        for (i = 0; i < m * n; i++) begin
            a_model[i]   = random_value(16);
            prod         = a_model[i] * k;
            res_model[i] = prod[15:0];  // Wraps modulo 65536
            cmd          = $sformatf("%s%0d ", cmd, a_model[i]);
        end
        cmd      = $sformatf("%s%0d ", cmd, k);
        expected = format_result(m, n);
    endtask

    task automatic build_transpose(input int m, input int n, output string cmd,
                                   output string expected);
        int r;
        int c;
        int i;
        cmd = $sformatf("%0d\n%0d,%0d ", int'(matcalc_pkg::OP_TRANSPOSE), m, n);
        for (i = 0; i < m * n; i++) begin
            a_model[i] = random_value(16);
            cmd        = $sformatf("%s%0d%s", cmd, a_model[i], sep_text(i));
        end
        for (r = 0; r < n; r++) begin
            for (c = 0; c < m; c++) res_model[r * m + c] = a_model[c * n + r];
        end
        expected = format_result(n, m);
    endtask

    // --------------------------------------------------
    // Reply checking and test bookkeeping
    // --------------------------------------------------
    task automatic expect_reply(input string expected);
        string reply;
        bit    ok;
        bit    bad;
        int    i;
        collect_reply(reply, ok);
        if (ok) begin
            check_value("reply length", expected.len(), reply.len());
            bad = 1'b0;
            for (i = 0; i < expected.len() && i < reply.len(); i++) begin
                if (!bad) begin  // First wrong character only
                    check_value($sformatf("reply char %0d", i), expected[i], reply[i]);
                    bad = expected[i] != reply[i];
                end
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("Test %-22s ok", name);
        end else begin
            fail_count++;
            $display("Test %-22s failed", name);
        end
    endtask

    initial begin
        string cmd;
        string expected;
        int    errors_start;
        rst_n      = 1'b0;
        rx         = 1'b1;
        lfsr_state = 16'd8637;
        repeat (8) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        repeat (4) @(negedge clk);

        errors_start = error_count;
        build_add(2, 3, 1'b0, cmd, expected);
        send_string(cmd);
        expect_reply(expected);
        finish_test("add 2x3", errors_start);

        errors_start = error_count;
        build_scale(3, 2, cmd, expected);
        send_string(cmd);
        expect_reply(expected);
        finish_test("scale 3x2", errors_start);

        errors_start = error_count;
        build_transpose(4, 1, cmd, expected);
        send_string(cmd);
        expect_reply(expected);
        finish_test("transpose 4x1", errors_start);

        errors_start = error_count;
        send_string("7 ");
        build_add(2, 2, 1'b0, cmd, expected);
        send_string(cmd);  // Error reply overlaps this command
        expect_reply("E\n");
        expect_reply(expected);
        finish_test("bad opcode then add", errors_start);

        errors_start = error_count;
        send_string("1 5 ");
        expect_reply("E\n");
        finish_test("dimension 5", errors_start);

        errors_start = error_count;
        send_string("3 2 0 ");
        expect_reply("E\n");
        finish_test("dimension 0", errors_start);

        errors_start = error_count;
        build_add(4, 4, 1'b1, cmd, expected);
        send_string(cmd);
        expect_reply(expected);
        finish_test("add 4x4 with zeros", errors_start);

        $display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/matcalc_top.sv ====
module matcalc_top #(
    parameter int CLKS_PER_BIT = 868,
    parameter int TX_DEPTH     = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic tx
);
    matcalc_pkg::char_t      rx_byte;
    logic                    byte_valid;
    matcalc_pkg::elem_t      num;
    logic                    num_valid;
    matcalc_pkg::print_job_t job;
    logic                    job_start;
    logic                    job_done;
    matcalc_pkg::elem_addr_t rd_addr;
    matcalc_pkg::elem_t      rd_data;
    matcalc_pkg::char_t      push_char;
    logic                    push_valid;
    logic                    credit_return;

    // Input side
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk(clk), .rst_n(rst_n), .rx(rx), .rx_byte(rx_byte), .byte_valid(byte_valid)
    );

    num_parser u_parser (
        .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .byte_valid(byte_valid),
        .num(num), .num_valid(num_valid)
    );

    matrix_engine u_engine (
        .clk(clk), .rst_n(rst_n), .num(num), .num_valid(num_valid),
        .job(job), .job_start(job_start), .job_done(job_done),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    // Output side, credit link between printer and TX buffer
    matrix_printer #(.TX_DEPTH(TX_DEPTH)) u_printer (
        .clk(clk), .rst_n(rst_n), .job(job), .job_start(job_start), .job_done(job_done),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .push_char(push_char), .push_valid(push_valid), .credit_return(credit_return)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT), .TX_DEPTH(TX_DEPTH)) u_tx (
        .clk(clk), .rst_n(rst_n), .push_char(push_char), .push_valid(push_valid),
        .credit_return(credit_return), .tx(tx)
    );

endmodule

// ==== hw/uart_tx.sv ====
module uart_tx #(
    parameter int CLKS_PER_BIT = 868,
    parameter int TX_DEPTH     = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  matcalc_pkg::char_t push_char,
    input  logic               push_valid,
    output logic               credit_return,
    output logic               tx
);
    localparam int PW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
    localparam int CW = $clog2(TX_DEPTH + 1);
    localparam int BW = $clog2(CLKS_PER_BIT);

    matcalc_pkg::char_t fifo [TX_DEPTH];
    matcalc_pkg::char_t pop_char;
    logic [PW-1:0]      wr_ptr;
    logic [PW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic               bypass;
    logic               pop;
    logic               wr_en;
    logic               rd_en;
    logic               busy;
    logic               bit_end;
    logic               ser_free;
    logic [BW-1:0]      clk_cnt;
    logic [3:0]         bit_cnt;
    logic [8:0]         shift;  // Stop bit above the data

    assign bit_end  = busy && clk_cnt == BW'(CLKS_PER_BIT - 1);
    assign ser_free = !busy || (bit_end && bit_cnt == 4'd9);
    assign bypass   = count == '0;  // Empty buffer feeds the serializer directly
    assign pop      = ser_free && (!bypass || push_valid);
    assign pop_char = bypass ? push_char : fifo[rd_ptr];
    assign wr_en    = push_valid && !(pop && bypass);
    assign rd_en    = pop && !bypass;

    // --------------------------------------------------
    // Character buffer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) fifo[wr_ptr] <= push_char;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
            if (wr_en) wr_ptr <= (wr_ptr == PW'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == PW'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(wr_en) - CW'(rd_en);
        end
    end

    // --------------------------------------------------
    // Serializer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            tx      <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shift   <= '1;
        end else if (pop) begin  // Start bit goes out next cycle
            busy    <= 1'b1;
            tx      <= 1'b0;
            shift   <= {1'b1, pop_char};
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (bit_end) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    tx      <= shift[0];
                    shift   <= {1'b1, shift[8:1]};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/matrix_printer.sv ====
module matrix_printer #(
    parameter int TX_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  matcalc_pkg::print_job_t job,
    input  logic                    job_start,
    output logic                    job_done,
    output matcalc_pkg::elem_addr_t rd_addr,
    input  matcalc_pkg::elem_t      rd_data,
    output matcalc_pkg::char_t      push_char,
    output logic                    push_valid,
    input  logic                    credit_return
);
    localparam int CW = $clog2(TX_DEPTH + 1);

    matcalc_pkg::printer_state_e state;
    matcalc_pkg::print_job_t     cur;
    matcalc_pkg::idx_t           row;
    matcalc_pkg::idx_t           col;
    matcalc_pkg::elem_t          val;
    logic [3:0]                  digits [5];  // Index 0 is the units digit
    logic [2:0]                  dig_idx;
    logic                        started;
    logic [CW-1:0]               credits;
    logic                        want;
    logic                        skip;
    logic                        last_col;
    logic                        last_row;

    assign rd_addr    = '{row: row, col: col};
    assign last_col   = col == matcalc_pkg::idx_t'(cur.cols - 3'd1);
    assign last_row   = row == matcalc_pkg::idx_t'(cur.rows - 3'd1);
    assign skip       = !started && digits[dig_idx] == 4'd0 && dig_idx != 3'd0;
    assign job_done   = state == matcalc_pkg::P_DONE;
    assign push_valid = want && credits != '0;

    // --------------------------------------------------
    // Character selection
    // --------------------------------------------------
    always_comb begin
        want      = 1'b1;
        push_char = "\n";
        case (state)
            matcalc_pkg::P_OPEN:  push_char = "[";
            matcalc_pkg::P_DIGIT: begin
                want      = !skip;
                push_char = {4'h3, digits[dig_idx]};
            end
            matcalc_pkg::P_SEP:     push_char = last_col ? "\n" : " ";
            matcalc_pkg::P_CLOSE:   push_char = "]";
            matcalc_pkg::P_ERR_E:   push_char = "E";
            matcalc_pkg::P_NEWLINE: push_char = "\n";
            default:                want = 1'b0;
        endcase
    end

    // Credits back from the TX buffer, one spent per push
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) credits <= CW'(TX_DEPTH);
        else credits <= credits + CW'(credit_return) - CW'(push_valid);
    end

    always_ff @(posedge clk) begin
        if (state == matcalc_pkg::P_IDLE && job_start) cur <= job;
        if (state == matcalc_pkg::P_LATCH) begin
            val <= rd_data;
        end else if (state == matcalc_pkg::P_CONVERT) begin
            digits[dig_idx] <= 4'(val % 16'd10);
            val             <= val / 16'd10;
        end
    end

    // --------------------------------------------------
    // Walk the result
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= matcalc_pkg::P_IDLE;
            row     <= '0;
            col     <= '0;
            dig_idx <= '0;
            started <= 1'b0;
        end else begin
            case (state)
                matcalc_pkg::P_IDLE: if (job_start) begin
                    row   <= '0;
                    col   <= '0;
                    state <= (job.kind == matcalc_pkg::JOB_ERROR) ?
                             matcalc_pkg::P_ERR_E : matcalc_pkg::P_OPEN;
                end
                matcalc_pkg::P_OPEN: if (push_valid) state <= matcalc_pkg::P_LATCH;
                matcalc_pkg::P_LATCH: begin
                    dig_idx <= '0;
                    state   <= matcalc_pkg::P_CONVERT;
                end
                matcalc_pkg::P_CONVERT: begin  // Five divide steps
                    dig_idx <= dig_idx + 3'd1;
                    if (dig_idx == 3'd4) begin
                        dig_idx <= 3'd4;
                        started <= 1'b0;
                        state   <= matcalc_pkg::P_DIGIT;
                    end
                end
                matcalc_pkg::P_DIGIT: begin
                    if (skip) begin
                        dig_idx <= dig_idx - 3'd1;  // Leading zero
                    end else if (push_valid) begin
                        started <= 1'b1;
                        if (dig_idx != 3'd0) dig_idx <= dig_idx - 3'd1;
                        else if (last_col && last_row) state <= matcalc_pkg::P_CLOSE;
                        else state <= matcalc_pkg::P_SEP;
                    end
                end
                matcalc_pkg::P_SEP: if (push_valid) begin
                    if (last_col) begin
                        col <= '0;
                        row <= row + 2'd1;
                    end else begin
                        col <= col + 2'd1;
                    end
                    state <= matcalc_pkg::P_LATCH;
                end
                matcalc_pkg::P_CLOSE, matcalc_pkg::P_ERR_E: begin
                    if (push_valid) state <= matcalc_pkg::P_NEWLINE;
                end
                matcalc_pkg::P_NEWLINE: if (push_valid) state <= matcalc_pkg::P_DONE;
                default: state <= matcalc_pkg::P_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/matrix_engine.sv ====
module matrix_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  matcalc_pkg::elem_t      num,
    input  logic                    num_valid,
    output matcalc_pkg::print_job_t job,
    output logic                    job_start,
    input  logic                    job_done,
    input  matcalc_pkg::elem_addr_t rd_addr,
    output matcalc_pkg::elem_t      rd_data
);
    matcalc_pkg::engine_state_e state;
    matcalc_pkg::op_e           op;
    matcalc_pkg::dim_t          m;
    matcalc_pkg::dim_t          n;
    matcalc_pkg::idx_t          row;
    matcalc_pkg::idx_t          col;
    matcalc_pkg::elem_t         mat_a [matcalc_pkg::MAX_ELEMS];
    matcalc_pkg::elem_t         mat_b [matcalc_pkg::MAX_ELEMS];
    matcalc_pkg::elem_t         scalar;
    matcalc_pkg::elem_t         a_val;
    logic                       op_ok;
    logic                       dim_ok;
    logic                       last_col;
    logic                       last_elem;

    assign op_ok     = num != '0 && num <= 16'(matcalc_pkg::OP_TRANSPOSE);
    assign dim_ok    = num != '0 && num <= 16'(matcalc_pkg::MAX_DIM);
    assign last_col  = col == matcalc_pkg::idx_t'(n - 3'd1);
    assign last_elem = last_col && row == matcalc_pkg::idx_t'(m - 3'd1);
    assign job_start = state == matcalc_pkg::S_PRINT;  // One cycle, then S_WAIT

    // --------------------------------------------------
    // Command sequencing
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= matcalc_pkg::S_OP;
            op    <= matcalc_pkg::OP_ADD;
            m     <= '0;
            n     <= '0;
            row   <= '0;
            col   <= '0;
            job   <= '0;
        end else begin
            case (state)
                matcalc_pkg::S_OP: if (num_valid) begin
                    if (op_ok) begin
                        op    <= matcalc_pkg::op_e'(num[1:0]);
                        state <= matcalc_pkg::S_M;
                    end else begin
                        job   <= '{kind: matcalc_pkg::JOB_ERROR, rows: '0, cols: '0};
                        state <= matcalc_pkg::S_PRINT;
                    end
                end
                matcalc_pkg::S_M, matcalc_pkg::S_N: if (num_valid) begin
                    if (!dim_ok) begin
                        job   <= '{kind: matcalc_pkg::JOB_ERROR, rows: '0, cols: '0};
                        state <= matcalc_pkg::S_PRINT;
                    end else if (state == matcalc_pkg::S_M) begin
                        m     <= matcalc_pkg::dim_t'(num);
                        state <= matcalc_pkg::S_N;
                    end else begin
                        n     <= matcalc_pkg::dim_t'(num);
                        row   <= '0;
                        col   <= '0;
                        state <= matcalc_pkg::S_A;
                    end
                end
                matcalc_pkg::S_A, matcalc_pkg::S_B: if (num_valid) begin
                    if (last_col) begin  // Row-major walk
                        col <= '0;
                        row <= row + 2'd1;
                    end else begin
                        col <= col + 2'd1;
                    end
                    if (last_elem) begin
                        row <= '0;
                        col <= '0;
                        job <= '{kind: matcalc_pkg::JOB_RESULT, rows: m, cols: n};
                        if (state == matcalc_pkg::S_B) begin
                            state <= matcalc_pkg::S_PRINT;
                        end else begin
                            case (op)
                                matcalc_pkg::OP_ADD:   state <= matcalc_pkg::S_B;
                                matcalc_pkg::OP_SCALE: state <= matcalc_pkg::S_K;
                                default: begin  // Transpose swaps the shape
                                    job   <= '{kind: matcalc_pkg::JOB_RESULT, rows: n, cols: m};
                                    state <= matcalc_pkg::S_PRINT;
                                end
                            endcase
                        end
                    end
                end
                matcalc_pkg::S_K: if (num_valid) begin
                    state <= matcalc_pkg::S_PRINT;
                end
                matcalc_pkg::S_PRINT: state <= matcalc_pkg::S_WAIT;
                matcalc_pkg::S_WAIT:  if (job_done) state <= matcalc_pkg::S_OP;  // Input dropped
                default: state <= matcalc_pkg::S_OP;
            endcase
        end
    end

    // --------------------------------------------------
    // Operand storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (num_valid) begin
            if (state == matcalc_pkg::S_A) mat_a[{row, col}] <= num;
            if (state == matcalc_pkg::S_B) mat_b[{row, col}] <= num;
            if (state == matcalc_pkg::S_K) scalar <= num;
        end
    end

    // Result element for the printer's read port
    always_comb begin
        if (op == matcalc_pkg::OP_TRANSPOSE) a_val = mat_a[{rd_addr.col, rd_addr.row}];
        else a_val = mat_a[{rd_addr.row, rd_addr.col}];
        case (op)
            matcalc_pkg::OP_ADD:   rd_data = a_val + mat_b[{rd_addr.row, rd_addr.col}];
            matcalc_pkg::OP_SCALE: rd_data = a_val * scalar;  // Low 16 bits kept
            default:               rd_data = a_val;
        endcase
    end

endmodule

// ==== hw/num_parser.sv ====
module num_parser (
    input  logic               clk,
    input  logic               rst_n,
    input  matcalc_pkg::char_t rx_byte,
    input  logic               byte_valid,
    output matcalc_pkg::elem_t num,
    output logic               num_valid
);
    matcalc_pkg::elem_t acc;
    logic               seen;
    logic               is_digit;

    assign is_digit = rx_byte >= "0" && rx_byte <= "9";

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            seen      <= 1'b0;
            num       <= '0;
            num_valid <= 1'b0;
        end else begin
            num_valid <= 1'b0;
            if (byte_valid) begin
                if (is_digit) begin
                    // acc * 10 + digit, wraps at 16 bits
                    acc  <= (acc << 3) + (acc << 1) + matcalc_pkg::elem_t'(rx_byte[3:0]);
                    seen <= 1'b1;
                end else begin
                    if (seen) begin
                        num       <= acc;
                        num_valid <= 1'b1;
                    end
                    acc  <= '0;
                    seen <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx,
    output matcalc_pkg::char_t rx_byte,
    output logic               byte_valid
);
    localparam int BW = $clog2(CLKS_PER_BIT);

    logic          rx_meta;
    logic          rx_sync;
    logic          busy;
    logic [BW-1:0] clk_cnt;
    logic [BW-1:0] target;
    logic [3:0]    bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [7:0]    shift;

    // Half period to reach mid start bit, full period afterwards
    assign target = (bit_cnt == 4'd0) ? BW'(CLKS_PER_BIT / 2 - 1) : BW'(CLKS_PER_BIT - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            clk_cnt    <= '0;
            bit_cnt    <= '0;
            shift      <= '0;
            rx_byte    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (!busy) begin
                if (!rx_sync) begin  // Falling edge of start bit
                    busy    <= 1'b1;
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (clk_cnt != target) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd0) begin
                    if (rx_sync) busy <= 1'b0;  // Glitch, not a start bit
                end else if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                    if (rx_sync) begin  // Framing error drops the byte
                        rx_byte    <= shift;
                        byte_valid <= 1'b1;
                    end
                end else begin
                    shift <= {rx_sync, shift[7:1]};  // LSB first
                end
            end
        end
    end

endmodule

// ==== hw/matcalc_pkg.sv ====
package matcalc_pkg;

    // --------------------------------------------------
    // Sizes and scalar types
    // --------------------------------------------------
    localparam int MAX_DIM   = 4;
    localparam int MAX_ELEMS = 16;

    typedef logic [15:0] elem_t;  // Element, scalar or parsed number
    typedef logic [2:0]  dim_t;   // Row or column count 0..4
    typedef logic [1:0]  idx_t;
    typedef logic [7:0]  char_t;

    // --------------------------------------------------
    // Enums
    // --------------------------------------------------
    typedef enum logic [1:0] {
        OP_ADD       = 2'd1,
        OP_SCALE     = 2'd2,
        OP_TRANSPOSE = 2'd3
    } op_e;

    typedef enum logic {
        JOB_RESULT = 1'b0,
        JOB_ERROR  = 1'b1
    } job_kind_e;

    typedef enum logic [2:0] {
        S_OP, S_M, S_N, S_A, S_B, S_K, S_PRINT, S_WAIT
    } engine_state_e;

    typedef enum logic [3:0] {
        P_IDLE, P_OPEN, P_LATCH, P_CONVERT, P_DIGIT,
        P_SEP, P_CLOSE, P_NEWLINE, P_ERR_E, P_DONE
    } printer_state_e;

    // --------------------------------------------------
    // Structs between engine and printer
    // --------------------------------------------------
    typedef struct packed {
        job_kind_e kind;
        dim_t      rows;
        dim_t      cols;
    } print_job_t;

    typedef struct packed {
        idx_t row;
        idx_t col;
    } elem_addr_t;

endpackage
